//--- compile.f
+incdir+hw
hw/bridge_pkg.sv
hw/access_check.sv
hw/ahb_slave_ctrl.sv
hw/cmd_buffer.sv
hw/ahb2axi_bridge.sv
tests/axi_slave_model.sv
tests/tb_ahb2axi.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_ahb2axi -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^TEST PASS$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tests/tb_ahb2axi.sv
// Testbench for the AHB-Lite to AXI bridge with an AHB master, expected
// results from the access rules and a process comparing AXI and AHB results

`include "bridge_params.svh"

module tb_ahb2axi;

  timeunit 1ns;
  timeprecision 100ps;

  // 200 transfers at about 25 cycles each, plus margin
  localparam int max_xfers  = 200;
  localparam int cyc_per    = 25;
  localparam int cyc_limit  = max_xfers * cyc_per + 1000;
  localparam logic [31:0] err_addr = `DCCM_BASE + 32'h0000_07f0;

  typedef struct packed {
    logic        write;
    logic [2:0]  size;
    logic [31:0] addr;
    logic [63:0] data;
  } xfer_t;

  typedef struct {
    xfer_t       x;
    string       name;
    logic        err;
    logic        first_low;
    logic [63:0] rdata;
  } result_t;

  typedef struct {
    xfer_t x;
    string name;
  } exp_cmd_t;

  logic                   bus_clk;
  logic                   rst_l;
  bridge_pkg::ahb_req_t   ahb_req;
  logic [63:0]            hwdata;
  logic                   hreadyin;
  logic [63:0]            hrdata;
  logic                   hreadyout;
  logic                   hresp;
  bridge_pkg::axi_cmd_t   aw_cmd;
  logic                   aw_valid;
  logic                   aw_ready;
  bridge_pkg::axi_wdata_t w_data;
  logic                   w_valid;
  logic                   w_ready;
  bridge_pkg::axi_cmd_t   ar_cmd;
  logic                   ar_valid;
  logic                   ar_ready;
  bridge_pkg::axi_rdata_t r_data;
  logic                   r_valid;
  logic                   seen_valid;
  logic                   seen_write;
  logic                   seen_wvalid;
  bridge_pkg::axi_cmd_t   seen_cmd;
  bridge_pkg::axi_wdata_t seen_wdata;

  integer   seed;
  int       cycles;
  string    test_name;
  xfer_t    pend_q[$];
  exp_cmd_t exp_q[$];
  result_t  res_q[$];
  exp_cmd_t e;
  result_t  r;

  ahb2axi_bridge UUT (
    .bus_clk(bus_clk), .rst_l(rst_l), .ahb_req(ahb_req), .hwdata(hwdata),
    .hreadyin(hreadyin), .hrdata(hrdata), .hreadyout(hreadyout), .hresp(hresp),
    .aw_cmd(aw_cmd), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w_data(w_data), .w_valid(w_valid), .w_ready(w_ready),
    .ar_cmd(ar_cmd), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r_data(r_data), .r_valid(r_valid)
  );

  axi_slave_model #(.err_addr(err_addr)) u_slave (
    .bus_clk(bus_clk), .rst_l(rst_l), .aw_cmd(aw_cmd), .aw_valid(aw_valid),
    .aw_ready(aw_ready), .w_data(w_data), .w_valid(w_valid), .w_ready(w_ready),
    .ar_cmd(ar_cmd), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r_data(r_data), .r_valid(r_valid), .seen_valid(seen_valid),
    .seen_write(seen_write), .seen_wvalid(seen_wvalid), .seen_cmd(seen_cmd),
    .seen_wdata(seen_wdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////////////////////////

  // Region, size and alignment rules of the bridge
  function automatic logic expect_err(input xfer_t x);
    logic dccm;
    logic iccm;
    logic bad_size;
    logic misal;
    dccm     = (x.addr >> `REGION_MASK_BITS) == (`DCCM_BASE >> `REGION_MASK_BITS);
    iccm     = (`ICCM_EN != 0) &&
               ((x.addr >> `REGION_MASK_BITS) == (`ICCM_BASE >> `REGION_MASK_BITS));
    bad_size = (x.size < 3'd2) && (iccm || (dccm && x.write));
    misal    = (x.addr & ((32'd1 << x.size) - 32'd1)) != 32'd0;
    return !(dccm || iccm) || bad_size || misal;
  endfunction

  // One lane per byte of the transfer, starting at its byte offset
  function automatic logic [7:0] expect_strb(input xfer_t x);
    int unsigned nbytes;
    nbytes = 1 << x.size;
    return 8'(((16'd1 << nbytes) - 16'd1) << x.addr[2:0]);
  endfunction

  // Same pattern the slave model serves
  function automatic logic [63:0] expect_rdata(input logic [31:0] addr);
    return {addr ^ 32'h3c5a_96e1, ~addr + 32'd7};
  endfunction

  task automatic check_value(input string name, input logic [71:0] expected,
                             input logic [71:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AHB master
  //////////////////////////////////////////////////////////////////////

  // Queue one transfer; only legal ones should reach AXI
  task automatic add_xfer(input logic write, input logic [2:0] size,
                          input logic [31:0] addr);
    xfer_t x;
    x.write = write;
    x.size  = size;
    x.addr  = addr;
    x.data  = {$random(seed), $random(seed)};
    pend_q.push_back(x);
    if (!expect_err(x)) begin
      exp_q.push_back('{x: x, name: test_name});
    end
  endtask

  // Pipelined issue; called and returns at a rising edge plus 2 ns
  task automatic run_xfers();
    xfer_t       dp;
    logic        dp_on;
    logic        err_seen;
    logic        rdy;
    logic        rsp;
    logic [63:0] rd;
    dp       = '0;
    dp_on    = 1'b0;
    err_seen = 1'b0;
    while (pend_q.size() != 0 || dp_on) begin
      // No new address during the second error cycle
      if (pend_q.size() != 0 && !err_seen) begin
        ahb_req = '{sel: 1'b1, trans: 2'b10, write: pend_q[0].write,
                    size: pend_q[0].size, addr: pend_q[0].addr};
      end else begin
        ahb_req = '0;
      end
      hwdata = (dp_on && dp.write) ? dp.data : 64'd0;
      @(negedge bus_clk);
      rdy = hreadyout;
      rsp = hresp;
      rd  = hrdata;
      @(posedge bus_clk);
      #2;
      if (dp_on && rdy) begin
        res_q.push_back('{x: dp, name: test_name, err: rsp, first_low: err_seen,
                          rdata: rd});
        dp_on    = 1'b0;
        err_seen = 1'b0;
      end else if (dp_on && rsp) begin
        err_seen = 1'b1;
      end
      if (rdy && ahb_req.sel) begin
        dp    = pend_q.pop_front();
        dp_on = 1'b1;
      end
    end
    ahb_req = '0;
    hwdata  = '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Comparing process
  //////////////////////////////////////////////////////////////////////

  always @(posedge bus_clk) begin
    if (seen_valid) begin
      if (exp_q.size() == 0) begin
        $display("An AXI command arrived that no AHB transfer should produce");
        $display("TEST FAIL");
        $fatal(1, "extra command");
      end else begin
        e = exp_q.pop_front();
        check_value({e.name, " cmd write"}, 72'(e.x.write), 72'(seen_write));
        // Write data is valid exactly with a write command
        check_value({e.name, " w_valid"}, 72'(e.x.write), 72'(seen_wvalid));
        check_value({e.name, " cmd addr"}, 72'(e.x.addr), 72'(seen_cmd.addr));
        check_value({e.name, " cmd size"}, 72'(e.x.size[1:0]), 72'(seen_cmd.size));
        if (e.x.write) begin
          check_value({e.name, " wdata"}, 72'(e.x.data), 72'(seen_wdata.data));
          check_value({e.name, " wstrb"}, 72'(expect_strb(e.x)), 72'(seen_wdata.strb));
        end
      end
    end
    if (res_q.size() != 0) begin
      r = res_q.pop_front();
      // A read of the error address fails on the AXI side
      check_value({r.name, " hresp"},
                  72'(expect_err(r.x) || (!r.x.write && r.x.addr == err_addr)),
                  72'(r.err));
      if (r.err) begin
        check_value({r.name, " first error cycle"}, 72'(1), 72'(r.first_low));
      end else if (!r.x.write) begin
        check_value({r.name, " hrdata"}, 72'(expect_rdata(r.x.addr)), 72'(r.rdata));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Clock, reset and timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    bus_clk = 1'b0;
    forever #20 bus_clk = ~bus_clk;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge bus_clk);
      cycles = cycles + 1;
      if (cycles >= cyc_limit) begin
        $display("Timeout after %0d cycles, the bridge stopped responding", cycles);
        $display("TEST FAIL");
        $fatal(1, "timeout");
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] base;
    logic [31:0] off;
    logic        wr;
    logic [2:0]  sz;
    seed     = 90;
    rst_l    = 1'b0;
    ahb_req  = '0;
    hwdata   = '0;
    hreadyin = 1'b1;
    repeat (3) @(posedge bus_clk);
    #2;
    rst_l = 1'b1;
    @(posedge bus_clk);
    #2;

    test_name = "writes";
    add_xfer(1'b1, 3'd3, `DCCM_BASE + 32'h0100);
    add_xfer(1'b1, 3'd2, `DCCM_BASE + 32'h0204);
    add_xfer(1'b1, 3'd3, `ICCM_BASE + 32'h0040);
    add_xfer(1'b1, 3'd2, `ICCM_BASE + 32'h008c);
    run_xfers();

    test_name = "aligned_reads";
    add_xfer(1'b0, 3'd0, `DCCM_BASE + 32'h0301);
    add_xfer(1'b0, 3'd1, `DCCM_BASE + 32'h0302);
    add_xfer(1'b0, 3'd2, `DCCM_BASE + 32'h0304);
    add_xfer(1'b0, 3'd3, `DCCM_BASE + 32'h0308);
    add_xfer(1'b0, 3'd2, `ICCM_BASE + 32'h0010);
    add_xfer(1'b0, 3'd3, `ICCM_BASE + 32'h0018);
    run_xfers();

    // Legal writes in between keep the FSM recovering into WR
    test_name = "access_errors";
    add_xfer(1'b0, 3'd2, 32'h1000_0000);
    add_xfer(1'b1, 3'd3, 32'h2000_0008);
    add_xfer(1'b0, 3'd1, `DCCM_BASE + 32'h0003);
    add_xfer(1'b1, 3'd3, `DCCM_BASE + 32'h0400);
    add_xfer(1'b0, 3'd2, `DCCM_BASE + 32'h0002);
    add_xfer(1'b0, 3'd3, `DCCM_BASE + 32'h0004);
    add_xfer(1'b0, 3'd0, `ICCM_BASE + 32'h0020);
    add_xfer(1'b0, 3'd1, `ICCM_BASE + 32'h0022);
    add_xfer(1'b1, 3'd0, `DCCM_BASE + 32'h0011);
    add_xfer(1'b1, 3'd2, `ICCM_BASE + 32'h0030);
    run_xfers();

    test_name = "read_error";
    add_xfer(1'b0, 3'd3, err_addr);
    add_xfer(1'b0, 3'd3, err_addr + 32'd8);
    run_xfers();

    // Back-to-back mix of legal transfers under random stalls
    test_name = "random_mix";
    repeat (150) begin
      wr   = $random(seed) & 1;
      base = ((`ICCM_EN != 0) && ($random(seed) & 1)) ? `ICCM_BASE : `DCCM_BASE;
      if (wr || base == `ICCM_BASE) begin
        sz = 3'd2 + 3'($random(seed) & 1);
      end else begin
        sz = 3'($random(seed) & 3);
      end
      off = $random(seed) & 32'h0000_fff8;
      off = off | (($random(seed) & 32'd7) & ~((32'd1 << sz) - 32'd1));
      add_xfer(wr, sz, base | off);
    end
    run_xfers();

    while (exp_q.size() != 0 || res_q.size() != 0) begin
      @(posedge bus_clk);
    end
    // Give a stray command time to show, then look at an idle bus
    repeat (5) @(negedge bus_clk);
    if (aw_valid || w_valid || ar_valid || hresp || !hreadyout) begin
      $display("The bridge did not return to idle after the last transfer");
      $display("TEST FAIL");
      $fatal(1, "not idle");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- tests/axi_slave_model.sv
// AXI slave for the bridge testbench with random ready stalls, read data from
// an address pattern and a one-cycle record of each accepted command

`include "bridge_params.svh"

module axi_slave_model #(
  parameter logic [`BRIDGE_ADDR_W-1:0] err_addr = '0
) (
  input  logic                   bus_clk,
  input  logic                   rst_l,
  input  bridge_pkg::axi_cmd_t   aw_cmd,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  bridge_pkg::axi_wdata_t w_data,
  input  logic                   w_valid,
  output logic                   w_ready,
  input  bridge_pkg::axi_cmd_t   ar_cmd,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  output bridge_pkg::axi_rdata_t r_data,
  output logic                   r_valid,
  output logic                   seen_valid,
  output logic                   seen_write,
  output logic                   seen_wvalid,
  output bridge_pkg::axi_cmd_t   seen_cmd,
  output bridge_pkg::axi_wdata_t seen_wdata
);

  timeunit 1ns;
  timeprecision 100ps;

  integer                    seed;
  int                        stall;
  int                        rd_cnt;
  logic                      aw_hs;
  logic                      ar_hs;
  logic [`BRIDGE_ADDR_W-1:0] rd_addr;

  // Memory contents seen by reads, spread over the whole address
  function automatic logic [`BRIDGE_DATA_W-1:0] mem_word(input logic [31:0] addr);
    return {addr ^ 32'h3c5a_96e1, ~addr + 32'd7};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Handshake sampling and response
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed        = 90;
    stall       = 0;
    rd_cnt      = 0;
    rd_addr     = '0;
    aw_ready    = 1'b0;
    w_ready     = 1'b0;
    ar_ready    = 1'b0;
    r_valid     = 1'b0;
    r_data      = '0;
    seen_valid  = 1'b0;
    seen_write  = 1'b0;
    seen_wvalid = 1'b0;
    seen_cmd    = '0;
    seen_wdata  = '0;
    forever begin
      // Mid-cycle values equal what the next rising edge sees
      @(negedge bus_clk);
      aw_hs       = aw_valid & aw_ready;
      ar_hs       = ar_valid & ar_ready;
      seen_valid  = aw_hs | ar_hs;
      seen_write  = aw_hs;
      seen_wvalid = w_valid;
      seen_cmd    = aw_hs ? aw_cmd : ar_cmd;
      seen_wdata  = w_data;
      if (ar_hs) begin
        rd_addr = ar_cmd.addr;
      end
      @(posedge bus_clk);
      #2;
      if (!rst_l) begin
        stall  = 0;
        rd_cnt = 0;
      end else if (aw_hs | ar_hs) begin
        // New stall of 0 to 3 cycles for the next command
        stall = $random(seed) & 3;
      end else if (stall != 0) begin
        stall = stall - 1;
      end
      if (ar_hs) begin
        rd_cnt = 1 + ($random(seed) & 3);
      end
      r_valid = 1'b0;
      if (rd_cnt != 0) begin
        rd_cnt = rd_cnt - 1;
        if (rd_cnt == 0) begin
          r_valid = 1'b1;
          r_data  = '{data: mem_word(rd_addr),
                      resp: (rd_addr == err_addr) ? 2'b10 : 2'b00};
        end
      end
      aw_ready = rst_l && (stall == 0);
      ar_ready = rst_l && (stall == 0);
      // Write data goes with the address handshake
      w_ready  = aw_ready;
    end
  end

endmodule

//--- hw/ahb2axi_bridge.sv
// AHB-Lite slave to AXI master bridge for the core's DCCM and ICCM
// Top level; connects the AHB controller, access check and command buffer

`include "bridge_params.svh"

module ahb2axi_bridge (
  input  logic                      bus_clk,
  input  logic                      rst_l,

  // AHB-Lite slave
  input  bridge_pkg::ahb_req_t      ahb_req,
  input  logic [`BRIDGE_DATA_W-1:0] hwdata,
  input  logic                      hreadyin,
  output logic [`BRIDGE_DATA_W-1:0] hrdata,
  output logic                      hreadyout,
  output logic                      hresp,

  // AXI write address and data
  output bridge_pkg::axi_cmd_t      aw_cmd,
  output logic                      aw_valid,
  input  logic                      aw_ready,
  output bridge_pkg::axi_wdata_t    w_data,
  output logic                      w_valid,
  input  logic                      w_ready,

  // AXI read address and data
  output bridge_pkg::axi_cmd_t      ar_cmd,
  output logic                      ar_valid,
  input  logic                      ar_ready,
  input  bridge_pkg::axi_rdata_t    r_data,
  input  logic                      r_valid
);

  // w_ready is not looked at since the slave takes write data with
  // the address handshake

  bridge_pkg::ahb_phase_t phase;
  logic                   access_err;
  logic                   cmd_load;
  logic                   cmd_full;

  //////////////////////////////////////////////////////////////////////
  // AHB side
  //////////////////////////////////////////////////////////////////////

  ahb_slave_ctrl u_ctrl (
    .bus_clk    (bus_clk),
    .rst_l      (rst_l),
    .ahb_req    (ahb_req),
    .hreadyin   (hreadyin),
    .hrdata     (hrdata),
    .hreadyout  (hreadyout),
    .hresp      (hresp),
    .phase      (phase),
    .access_err (access_err),
    .cmd_load   (cmd_load),
    .cmd_full   (cmd_full),
    .r_data     (r_data),
    .r_valid    (r_valid)
  );

  access_check u_check (
    .phase      (phase),
    .access_err (access_err)
  );

  //////////////////////////////////////////////////////////////////////
  // AXI side
  //////////////////////////////////////////////////////////////////////

  // hresp doubles as the drop request for a buffered read
  cmd_buffer u_cmd_buf (
    .bus_clk  (bus_clk),
    .rst_l    (rst_l),
    .cmd_load (cmd_load),
    .drop     (hresp),
    .phase    (phase),
    .hwdata   (hwdata),
    .full     (cmd_full),
    .aw_cmd   (aw_cmd),
    .aw_valid (aw_valid),
    .w_data   (w_data),
    .w_valid  (w_valid),
    .aw_ready (aw_ready),
    .ar_cmd   (ar_cmd),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready)
  );

endmodule

//--- hw/cmd_buffer.sv
// Single-entry AXI command holding register between the AHB controller
// and the AXI write-address, write-data and read-address channels

`include "bridge_params.svh"

module cmd_buffer (
  input  logic                      bus_clk,
  input  logic                      rst_l,
  input  logic                      cmd_load,
  input  logic                      drop,
  input  bridge_pkg::ahb_phase_t    phase,
  input  logic [`BRIDGE_DATA_W-1:0] hwdata,
  output logic                      full,
  output bridge_pkg::axi_cmd_t      aw_cmd,
  output logic                      aw_valid,
  output bridge_pkg::axi_wdata_t    w_data,
  output logic                      w_valid,
  input  logic                      aw_ready,
  output bridge_pkg::axi_cmd_t      ar_cmd,
  output logic                      ar_valid,
  input  logic                      ar_ready
);

  logic                      vld;
  logic                      is_write;
  logic                      accept;
  logic                      clr;
  logic [`BRIDGE_STRB_W-1:0] strb;
  bridge_pkg::axi_cmd_t      cmd_q;
  bridge_pkg::axi_wdata_t    wdata_q;

  //////////////////////////////////////////////////////////////////////
  // Write strobe
  //////////////////////////////////////////////////////////////////////

  // Lanes from size, shifted to the byte offset
  always_comb begin
    case (phase.size)
      3'd0:    strb = `BRIDGE_STRB_W'(8'b0000_0001) << phase.addr[2:0];
      3'd1:    strb = `BRIDGE_STRB_W'(8'b0000_0011) << phase.addr[2:0];
      3'd2:    strb = `BRIDGE_STRB_W'(8'b0000_1111) << phase.addr[2:0];
      3'd3:    strb = '1;
      default: strb = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Entry state
  //////////////////////////////////////////////////////////////////////

  // Either address channel handshake empties the entry
  assign accept = (aw_valid & aw_ready) | (ar_valid & ar_ready);

  // A same-cycle load refills it; an erroring read is thrown away
  assign clr  = (accept & ~cmd_load) | (drop & ~is_write);
  assign full = vld & ~accept;

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      vld      <= 1'b0;
      is_write <= 1'b0;
    end else begin
      vld <= ~clr & (cmd_load | vld);
      if (cmd_load) begin
        is_write <= phase.write;
      end
    end
  end

  // Payload, valid only while vld is set
  always_ff @(posedge bus_clk) begin
    if (cmd_load) begin
      cmd_q   <= '{addr: phase.addr, size: phase.size[1:0]};
      wdata_q <= '{data: hwdata, strb: strb};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AXI channels
  //////////////////////////////////////////////////////////////////////

  assign aw_cmd   = cmd_q;
  assign aw_valid = vld & is_write;

  // Data is loaded with its command, so both valids rise together
  assign w_data  = wdata_q;
  assign w_valid = vld & is_write;

  assign ar_cmd   = cmd_q;
  assign ar_valid = vld & ~is_write;

endmodule

//--- hw/ahb_slave_ctrl.sv
// AHB-Lite slave side of the bridge with the transfer FSM, address phase
// capture, hreadyout/hresp generation and the read data buffer

`include "bridge_params.svh"

module ahb_slave_ctrl (
  input  logic                       bus_clk,
  input  logic                       rst_l,
  input  bridge_pkg::ahb_req_t       ahb_req,
  input  logic                       hreadyin,
  output logic [`BRIDGE_DATA_W-1:0]  hrdata,
  output logic                       hreadyout,
  output logic                       hresp,
  output bridge_pkg::ahb_phase_t     phase,
  input  logic                       access_err,
  output logic                       cmd_load,
  input  logic                       cmd_full,
  input  bridge_pkg::axi_rdata_t     r_data,
  input  logic                       r_valid
);

  bridge_pkg::buf_state_t state;
  bridge_pkg::buf_state_t nxt_state;
  logic                   state_en;

  // Captured address phase
  logic                      active_q;
  logic                      write_q;
  logic [2:0]                size_q;
  logic [`BRIDGE_ADDR_W-1:0] addr_q;

  // Read return
  logic                      rdata_en;
  logic                      read_err_in;
  logic                      read_err;
  logic [`BRIDGE_DATA_W-1:0] rdata_q;

  // History for the second error cycle
  logic hready;
  logic hready_q;
  logic hresp_q;
  logic phase_err;

  //////////////////////////////////////////////////////////////////////
  // Transfer FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_state   = bridge_pkg::IDLE;
    state_en    = 1'b0;
    rdata_en    = 1'b0;
    read_err_in = 1'b0;
    cmd_load    = 1'b0;
    case (state)
      bridge_pkg::IDLE: begin
        // Leave only on an accepted address phase
        nxt_state = ahb_req.write ? bridge_pkg::WR : bridge_pkg::RD;
        state_en  = hready & ahb_req.trans[1] & ahb_req.sel;
      end
      bridge_pkg::WR: begin
        // Back to idle on error or when no new transfer follows
        if (hresp | (ahb_req.trans == 2'b00) | ~ahb_req.sel) begin
          nxt_state = bridge_pkg::IDLE;
        end else begin
          nxt_state = ahb_req.write ? bridge_pkg::WR : bridge_pkg::RD;
        end
        state_en = ~cmd_full | hresp;
        // Hold the write back while the master is in BUSY
        cmd_load = ~cmd_full & ~(hresp | ((ahb_req.trans == 2'b01) & ahb_req.sel));
      end
      bridge_pkg::RD: begin
        nxt_state = hresp ? bridge_pkg::IDLE : bridge_pkg::PEND;
        state_en  = ~cmd_full | hresp;
        cmd_load  = ~cmd_full & ~hresp;
      end
      bridge_pkg::PEND: begin
        // Data goes out to AHB the cycle after it arrives
        nxt_state   = bridge_pkg::IDLE;
        state_en    = r_valid;
        rdata_en    = r_valid;
        read_err_in = r_valid & (|r_data.resp);
      end
      default: begin
        nxt_state = bridge_pkg::IDLE;
        state_en  = 1'b1;
      end
    endcase
  end

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      state <= bridge_pkg::IDLE;
    end else if (state_en) begin
      state <= nxt_state;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Address phase capture
  //////////////////////////////////////////////////////////////////////

  assign hready = hreadyout & hreadyin;

  // Transfer type is sampled every cycle
  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      active_q <= 1'b0;
    end else begin
      active_q <= ahb_req.sel & (|ahb_req.trans);
    end
  end

  // Control fields only on an accepted NONSEQ or SEQ
  always_ff @(posedge bus_clk) begin
    if (hready & ahb_req.sel & ahb_req.trans[1]) begin
      write_q <= ahb_req.write;
      size_q  <= ahb_req.size;
      addr_q  <= ahb_req.addr;
    end
  end

  assign phase = '{active: active_q, write: write_q, size: size_q, addr: addr_q};

  //////////////////////////////////////////////////////////////////////
  // Read data buffer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (rdata_en) begin
      rdata_q <= r_data.data;
    end
  end

  // High for exactly one cycle after an erroring read beat
  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      read_err <= 1'b0;
    end else begin
      read_err <= read_err_in;
    end
  end

  assign hrdata = rdata_q;

  //////////////////////////////////////////////////////////////////////
  // AHB response
  //////////////////////////////////////////////////////////////////////

  // Checked phase error, only while a transfer is in its data phase
  assign phase_err = (state != bridge_pkg::IDLE) & access_err;

  // Second cycle term keeps hresp up after a low-ready first cycle
  assign hresp = phase_err | read_err | (hresp_q & ~hready_q);

  // First error cycle stalls, second releases; otherwise stall on reads
  // and on a full buffer
  always_comb begin
    if (hresp) begin
      hreadyout = hresp_q & ~hready_q;
    end else begin
      hreadyout = (~cmd_full | (state == bridge_pkg::IDLE)) &
                  ~((state == bridge_pkg::RD) | (state == bridge_pkg::PEND));
    end
  end

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      hresp_q  <= 1'b0;
      hready_q <= 1'b0;
    end else begin
      hresp_q  <= hresp;
      hready_q <= hready;
    end
  end

endmodule

//--- hw/access_check.sv
// Region decode and size/alignment rules for a captured AHB address phase
// Purely combinational; the controller decides when the result counts

`include "bridge_params.svh"

module access_check (
  input  bridge_pkg::ahb_phase_t phase,
  output logic                   access_err
);

  localparam int unsigned addr_w = `BRIDGE_ADDR_W;
  localparam int unsigned mask_w = `REGION_MASK_BITS;
  localparam logic [addr_w-1:0] dccm_base = `DCCM_BASE;
  localparam logic [addr_w-1:0] iccm_base = `ICCM_BASE;
  localparam bit iccm_en = (`ICCM_EN != 0);

  logic in_dccm;
  logic in_iccm;
  logic unmapped;
  logic sub_word;
  logic size_err;
  logic hw_misalign;
  logic w_misalign;
  logic dw_misalign;

  //////////////////////////////////////////////////////////////////////
  // Region decode
  //////////////////////////////////////////////////////////////////////

  // Compare only the bits above the region window
  assign in_dccm = (phase.addr[addr_w-1:mask_w] == dccm_base[addr_w-1:mask_w]);

  // Without an ICCM every access to its range falls through as unmapped
  assign in_iccm = iccm_en &&
                   (phase.addr[addr_w-1:mask_w] == iccm_base[addr_w-1:mask_w]);

  assign unmapped = ~(in_dccm | in_iccm);

  //////////////////////////////////////////////////////////////////////
  // Size rules
  //////////////////////////////////////////////////////////////////////

  // Byte or halfword
  assign sub_word = ~phase.size[1];

  // ICCM takes only word and doubleword accesses
  // DCCM reads of any size are fine, writes must be a word or more
  assign size_err = sub_word & (in_iccm | (in_dccm & phase.write));

  //////////////////////////////////////////////////////////////////////
  // Alignment rules
  //////////////////////////////////////////////////////////////////////

  assign hw_misalign = (phase.size == 3'd1) & phase.addr[0];
  assign w_misalign  = (phase.size == 3'd2) & (|phase.addr[1:0]);
  assign dw_misalign = (phase.size == 3'd3) & (|phase.addr[2:0]);

  // Any one of the rules is enough to reject an active transfer
  assign access_err = phase.active &
                      (unmapped | size_err | hw_misalign | w_misalign | dw_misalign);

endmodule

//--- hw/bridge_pkg.sv
// Shared types of the AHB-Lite to AXI bridge
// Used by the RTL and the testbench through scoped names

`include "bridge_params.svh"

package bridge_pkg;

  //////////////////////////////////////////////////////////////////////
  // Controller state
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE = 2'b00,  // No transfer in flight
    WR   = 2'b01,  // Write data phase
    RD   = 2'b10,  // Read waiting for the command buffer
    PEND = 2'b11   // Read sent, waiting on AXI read data
  } buf_state_t;

  //////////////////////////////////////////////////////////////////////
  // AHB side
  //////////////////////////////////////////////////////////////////////

  // Address phase signals as driven by the master
  typedef struct packed {
    logic                      sel;
    logic [1:0]                trans;
    logic                      write;
    logic [2:0]                size;
    logic [`BRIDGE_ADDR_W-1:0] addr;
  } ahb_req_t;

  // Address phase held by the slave for its data phase
  typedef struct packed {
    logic                      active;
    logic                      write;
    logic [2:0]                size;
    logic [`BRIDGE_ADDR_W-1:0] addr;
  } ahb_phase_t;

  //////////////////////////////////////////////////////////////////////
  // AXI side
  //////////////////////////////////////////////////////////////////////

  // Write and read address channels, size limited to doubleword
  typedef struct packed {
    logic [`BRIDGE_ADDR_W-1:0] addr;
    logic [1:0]                size;
  } axi_cmd_t;

  typedef struct packed {
    logic [`BRIDGE_DATA_W-1:0] data;
    logic [`BRIDGE_STRB_W-1:0] strb;
  } axi_wdata_t;

  typedef struct packed {
    logic [`BRIDGE_DATA_W-1:0] data;
    logic [1:0]                resp;
  } axi_rdata_t;

endpackage

//--- hw/bridge_params.svh
// Widths and memory map of the AHB-Lite to AXI bridge
// Included by the package and by any RTL or test file that needs a constant

`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

// Address width, same on the AHB and AXI sides
`define BRIDGE_ADDR_W 32

// Data path width
`define BRIDGE_DATA_W 64

// One strobe bit per data byte
`define BRIDGE_STRB_W 8

//////////////////////////////////////////////////////////////////////
// Memory map
//////////////////////////////////////////////////////////////////////

// Tightly coupled data memory
`define DCCM_BASE 32'hf004_0000

// Tightly coupled instruction memory
`define ICCM_BASE 32'hee00_0000

// Low address bits ignored in the region compare
`define REGION_MASK_BITS 16

// Set to 0 when the core is built without an ICCM
`define ICCM_EN 1

`endif
